// File: hdl/adc_link_pkg.sv
`default_nettype none

package adc_link_pkg;

    ////////////////////
    // Widths and types
    ////////////////////
    localparam int NUM_CHAN = 16;               // ADC channels on the board
    localparam int SAMPLE_W = 12;               // Bits per ADC sample

    typedef logic [SAMPLE_W-1:0] sample_t;      // One ADC sample
    typedef logic [3:0]          chan_sel_t;    // Channel number
    typedef logic [15:0]         link_word_t;   // Serial-link data word
    typedef logic [1:0]          link_k_t;      // K flags, one per byte

    typedef logic [3:0]          axil_addr_t;   // Byte address, 16 byte window
    typedef logic [31:0]         axil_data_t;
    typedef logic [1:0]          axil_resp_t;

    ////////////////////
    // Constants
    ////////////////////
    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;
    localparam axil_addr_t CTRL_ADDR   = 4'h0;   // Control register
    localparam logic [7:0] COMMA_CHAR  = 8'hBC;  // K28.5

    // Bus channel FSMs
    typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;
    typedef enum logic {RD_IDLE, RD_RESP} rd_state_t;

endpackage

`default_nettype wire

// File: hdl/axil_if.sv
`timescale 1ns/10ps
`default_nettype none

interface axil_if;

    // Write address and data
    adc_link_pkg::axil_addr_t awaddr;
    logic                     awvalid;
    logic                     awready;
    adc_link_pkg::axil_data_t wdata;
    logic                     wvalid;
    logic                     wready;
    // Write response
    adc_link_pkg::axil_resp_t bresp;
    logic                     bvalid;
    logic                     bready;
    // Read address
    adc_link_pkg::axil_addr_t araddr;
    logic                     arvalid;
    logic                     arready;
    // Read data
    adc_link_pkg::axil_data_t rdata;
    adc_link_pkg::axil_resp_t rresp;
    logic                     rvalid;
    logic                     rready;

    modport slave (
        input  awaddr, awvalid, wdata, wvalid, bready, araddr, arvalid, rready,
        output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

    modport master (
        output awaddr, awvalid, wdata, wvalid, bready, araddr, arvalid, rready,
        input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

endinterface

`default_nettype wire

// File: hdl/axil_csr_regs.sv
`timescale 1ns/10ps
`default_nettype none

module axil_csr_regs (
    input  wire logic               CLK125,
    input  wire logic               rst_n_i,
    axil_if.slave                   axil,
    output adc_link_pkg::chan_sel_t chan_sel_o
);

    adc_link_pkg::wr_state_t  wr_state_q;
    adc_link_pkg::rd_state_t  rd_state_q;
    adc_link_pkg::axil_data_t ctrl_q;       // Control register
    adc_link_pkg::axil_resp_t bresp_q;
    adc_link_pkg::axil_data_t rdata_q;
    adc_link_pkg::axil_resp_t rresp_q;
    logic                     arready_q;

    logic wr_go;                            // AW and W accepted this edge
    logic wr_hit;                           // Write targets the control register
    logic rd_go;                            // AR accepted this edge
    logic rd_hit;

    ////////////////////
    // Write channel
    ////////////////////
    // Address and data taken together, only out of reset with no response pending
    assign wr_go  = rst_n_i & (wr_state_q == adc_link_pkg::WR_IDLE) & axil.awvalid & axil.wvalid;
    assign wr_hit = (axil.awaddr == adc_link_pkg::CTRL_ADDR);

    always_ff @(posedge CLK125 or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_state_q <= adc_link_pkg::WR_IDLE;
        end else begin
            case (wr_state_q)
                adc_link_pkg::WR_IDLE: if (wr_go) wr_state_q <= adc_link_pkg::WR_RESP;
                adc_link_pkg::WR_RESP: if (axil.bready) wr_state_q <= adc_link_pkg::WR_IDLE;
                default:               wr_state_q <= adc_link_pkg::WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK125 or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_q <= '0;
        end else if (wr_go && wr_hit) begin
            ctrl_q <= axil.wdata;           // Full 32 bits, no strobes
        end
    end

    always_ff @(posedge CLK125) begin
        if (wr_go) begin
            bresp_q <= wr_hit ? adc_link_pkg::RESP_OKAY : adc_link_pkg::RESP_SLVERR;
        end
    end

    assign axil.awready = wr_go;
    assign axil.wready  = wr_go;
    assign axil.bvalid  = (wr_state_q == adc_link_pkg::WR_RESP);   // Held until BREADY
    assign axil.bresp   = bresp_q;

    ////////////////////
    // Read channel
    ////////////////////
    assign rd_go  = arready_q & axil.arvalid;
    assign rd_hit = (axil.araddr == adc_link_pkg::CTRL_ADDR);

    always_ff @(posedge CLK125 or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_state_q <= adc_link_pkg::RD_IDLE;
            arready_q  <= 1'b0;                 // Low through reset
        end else begin
            case (rd_state_q)
                adc_link_pkg::RD_IDLE: begin
                    if (rd_go) begin
                        rd_state_q <= adc_link_pkg::RD_RESP;
                        arready_q  <= 1'b0;     // Busy until RREADY
                    end else begin
                        arready_q  <= 1'b1;
                    end
                end
                adc_link_pkg::RD_RESP: begin
                    if (axil.rready) begin
                        rd_state_q <= adc_link_pkg::RD_IDLE;
                        arready_q  <= 1'b1;
                    end
                end
                default: rd_state_q <= adc_link_pkg::RD_IDLE;
            endcase
        end
    end

    // Read data captured at the address handshake
    always_ff @(posedge CLK125) begin
        if (rd_go) begin
            rdata_q <= rd_hit ? ctrl_q : '0;    // Unmapped reads give zero
            rresp_q <= rd_hit ? adc_link_pkg::RESP_OKAY : adc_link_pkg::RESP_SLVERR;
        end
    end

    assign axil.arready = arready_q;
    assign axil.rvalid  = (rd_state_q == adc_link_pkg::RD_RESP);
    assign axil.rdata   = rdata_q;
    assign axil.rresp   = rresp_q;

    assign chan_sel_o = ctrl_q[3:0];            // Channel field

endmodule

`default_nettype wire

// File: hdl/chan_select.sv
`timescale 1ns/10ps
`default_nettype none

module chan_select (
    input  wire logic                                             CLK125,
    input  wire logic                                             rst_n_i,
    input  wire adc_link_pkg::sample_t [adc_link_pkg::NUM_CHAN-1:0] adc_samples_i,
    input  wire adc_link_pkg::chan_sel_t                          chan_sel_i,
    output adc_link_pkg::sample_t                                 sel_sample_o
);

    adc_link_pkg::sample_t mux_sample;     // Chosen channel, before the register

    ////////////////////
    // 16 to 1 mux
    ////////////////////
    // Channel k sits in bits 12k+11 down to 12k
    always_comb begin
        mux_sample = adc_samples_i[chan_sel_i];
    end

    // Stage 1 register
    always_ff @(posedge CLK125 or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sel_sample_o <= '0;
        end else begin
            sel_sample_o <= mux_sample;    // New channel shows one edge after the CSR write
        end
    end

endmodule

`default_nettype wire

// File: hdl/link_framer.sv
`timescale 1ns/10ps
`default_nettype none

module link_framer #(
    parameter int unsigned FRAME_LEN = 1024,    // Comma period, cycles
    parameter int unsigned COMMA_LEN = 10       // Comma burst length
) (
    input  wire logic                   CLK125,
    input  wire logic                   rst_n_i,
    input  wire adc_link_pkg::sample_t  sample_i,
    output adc_link_pkg::link_word_t    tx_data_o,
    output adc_link_pkg::link_k_t       tx_charisk_o
);

    localparam int CNT_W = $clog2(FRAME_LEN);
    localparam adc_link_pkg::link_k_t K_COMMA = 2'b01;  // Low byte is a K char
    localparam adc_link_pkg::link_k_t K_DATA  = 2'b00;

    logic [CNT_W-1:0] cnt_q;                // Frame position
    logic [7:0]       cnt_lo;               // Count sent beside the comma
    logic             in_comma;

    ////////////////////
    // Frame counter
    ////////////////////
    // Free running, wraps at FRAME_LEN
    always_ff @(posedge CLK125 or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (cnt_q == CNT_W'(FRAME_LEN - 1)) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign in_comma = (32'(cnt_q) < COMMA_LEN);
    assign cnt_lo   = 8'(cnt_q);            // Zero extended for short frames

    ////////////////////
    // Link word
    ////////////////////
    // Stage 2 register
    always_ff @(posedge CLK125 or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_data_o    <= '0;
            tx_charisk_o <= '0;
        end else if (in_comma) begin
            tx_data_o    <= {cnt_lo, adc_link_pkg::COMMA_CHAR};   // Alignment burst
            tx_charisk_o <= K_COMMA;
        end else begin
            tx_data_o    <= {4'h0, sample_i};  // Top nibble zero
            tx_charisk_o <= K_DATA;
        end
    end

endmodule

`default_nettype wire

// File: hdl/adc_link_top.sv
`timescale 1ns/10ps
`default_nettype none

module adc_link_top #(
    parameter int unsigned FRAME_LEN = 1024,
    parameter int unsigned COMMA_LEN = 10
) (
    input  wire logic                                               CLK125,
    input  wire logic                                               rst_n_i,
    // ADC samples, already parallel
    input  wire adc_link_pkg::sample_t [adc_link_pkg::NUM_CHAN-1:0] adc_samples_i,
    // AXI4-Lite slave
    input  wire adc_link_pkg::axil_addr_t  s_axil_awaddr_i,
    input  wire logic                      s_axil_awvalid_i,
    output logic                           s_axil_awready_o,
    input  wire adc_link_pkg::axil_data_t  s_axil_wdata_i,
    input  wire logic                      s_axil_wvalid_i,
    output logic                           s_axil_wready_o,
    output adc_link_pkg::axil_resp_t       s_axil_bresp_o,
    output logic                           s_axil_bvalid_o,
    input  wire logic                      s_axil_bready_i,
    input  wire adc_link_pkg::axil_addr_t  s_axil_araddr_i,
    input  wire logic                      s_axil_arvalid_i,
    output logic                           s_axil_arready_o,
    output adc_link_pkg::axil_data_t       s_axil_rdata_o,
    output adc_link_pkg::axil_resp_t       s_axil_rresp_o,
    output logic                           s_axil_rvalid_o,
    input  wire logic                      s_axil_rready_i,
    // Serial link
    output adc_link_pkg::link_word_t       tx_data_o,
    output adc_link_pkg::link_k_t          tx_charisk_o
);

    adc_link_pkg::chan_sel_t chan_sel;     // CSR to stage 1
    adc_link_pkg::sample_t   sel_sample;   // Stage 1 to stage 2

    ////////////////////
    // Bus hookup
    ////////////////////
    axil_if u_axil_if ();

    assign u_axil_if.awaddr  = s_axil_awaddr_i;
    assign u_axil_if.awvalid = s_axil_awvalid_i;
    assign u_axil_if.wdata   = s_axil_wdata_i;
    assign u_axil_if.wvalid  = s_axil_wvalid_i;
    assign u_axil_if.bready  = s_axil_bready_i;
    assign u_axil_if.araddr  = s_axil_araddr_i;
    assign u_axil_if.arvalid = s_axil_arvalid_i;
    assign u_axil_if.rready  = s_axil_rready_i;

    assign s_axil_awready_o = u_axil_if.awready;
    assign s_axil_wready_o  = u_axil_if.wready;
    assign s_axil_bresp_o   = u_axil_if.bresp;
    assign s_axil_bvalid_o  = u_axil_if.bvalid;
    assign s_axil_arready_o = u_axil_if.arready;
    assign s_axil_rdata_o   = u_axil_if.rdata;
    assign s_axil_rresp_o   = u_axil_if.rresp;
    assign s_axil_rvalid_o  = u_axil_if.rvalid;

    axil_csr_regs u_csr (
        .CLK125     (CLK125),
        .rst_n_i    (rst_n_i),
        .axil       (u_axil_if.slave),
        .chan_sel_o (chan_sel)
    );

    ////////////////////
    // Datapath
    ////////////////////
    chan_select u_chan_select (
        .CLK125        (CLK125),
        .rst_n_i       (rst_n_i),
        .adc_samples_i (adc_samples_i),
        .chan_sel_i    (chan_sel),
        .sel_sample_o  (sel_sample)
    );

    link_framer #(
        .FRAME_LEN (FRAME_LEN),
        .COMMA_LEN (COMMA_LEN)
    ) u_link_framer (
        .CLK125       (CLK125),
        .rst_n_i      (rst_n_i),
        .sample_i     (sel_sample),
        .tx_data_o    (tx_data_o),
        .tx_charisk_o (tx_charisk_o)
    );

endmodule

`default_nettype wire

// File: tests/adc_link_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module adc_link_assertions (
    input wire logic                     CLK125,
    input wire logic                     rst_n_i,
    input wire adc_link_pkg::link_word_t tx_data_i,
    input wire adc_link_pkg::link_k_t    tx_charisk_i,
    input wire logic                     bvalid_i,
    input wire logic                     bready_i,
    input wire logic                     rvalid_i,
    input wire logic                     rready_i
);

    ////////////////////
    // Link flags
    ////////////////////
    a_k_legal: assert property (@(posedge CLK125) disable iff (!rst_n_i)
        tx_charisk_i inside {2'b00, 2'b01}) else $error("Illegal K flags");
    a_k_comma: assert property (@(posedge CLK125) disable iff (!rst_n_i)
        tx_charisk_i == 2'b01 |-> tx_data_i[7:0] == adc_link_pkg::COMMA_CHAR)
        else $error("K flag without comma byte");

    // Responses wait for the master
    a_b_hold: assert property (@(posedge CLK125) disable iff (!rst_n_i)
        bvalid_i && !bready_i |=> bvalid_i) else $error("BVALID dropped early");
    a_r_hold: assert property (@(posedge CLK125) disable iff (!rst_n_i)
        rvalid_i && !rready_i |=> rvalid_i) else $error("RVALID dropped early");

endmodule

bind adc_link_top adc_link_assertions u_assertions (
    .CLK125(CLK125), .rst_n_i(rst_n_i), .tx_data_i(tx_data_o), .tx_charisk_i(tx_charisk_o),
    .bvalid_i(s_axil_bvalid_o), .bready_i(s_axil_bready_i),
    .rvalid_i(s_axil_rvalid_o), .rready_i(s_axil_rready_i)
);

`default_nettype wire

// File: tests/adc_link_checker.sv
`timescale 1ns/10ps
`default_nettype none

module adc_link_checker #(
    parameter int unsigned FRAME_LEN = 64,
    parameter int unsigned COMMA_LEN = 10
) (
    input wire logic                                               CLK125,
    input wire logic                                               rst_n_i,
    input wire adc_link_pkg::sample_t [adc_link_pkg::NUM_CHAN-1:0] adc_samples_i,
    input wire adc_link_pkg::axil_addr_t awaddr_i,
    input wire adc_link_pkg::axil_data_t wdata_i,
    input wire logic                     wr_hs_i,    // AW and W accepted
    input wire logic                     b_hs_i,
    input wire adc_link_pkg::axil_resp_t bresp_i,
    input wire adc_link_pkg::axil_addr_t araddr_i,
    input wire logic                     ar_hs_i,
    input wire logic                     r_hs_i,
    input wire adc_link_pkg::axil_data_t rdata_i,
    input wire adc_link_pkg::axil_resp_t rresp_i,
    input wire adc_link_pkg::link_word_t tx_data_i,
    input wire adc_link_pkg::link_k_t    tx_charisk_i
);

    int                       errors;
    int                       bus_errors = 0;   // Response mismatches
    int                       link_errors = 0;  // Link word mismatches
    int                       cnt_m = 0;        // Frame position
    adc_link_pkg::sample_t    stage_m = '0;     // Sample one edge old
    adc_link_pkg::axil_data_t ctrl_m = '0;      // Control register mirror
    logic [17:0]              exp_out = '0;     // {k, word} expected after the edge
    adc_link_pkg::axil_resp_t exp_bresp = '0;
    adc_link_pkg::axil_data_t exp_rdata = '0;
    adc_link_pkg::axil_resp_t exp_rresp = '0;
    logic [adc_link_pkg::NUM_CHAN*12-1:0] samples_flat;   // Channel k at bits 12k+11:12k

    assign samples_flat = adc_samples_i;
    assign errors       = bus_errors + link_errors;

    // Comma with count below COMMA_LEN, else padded sample
    function automatic logic [17:0] expected_link(input int cnt, input adc_link_pkg::sample_t s);
        if (cnt < int'(COMMA_LEN)) return {2'b01, 8'(cnt), adc_link_pkg::COMMA_CHAR};
        return {2'b00, 4'h0, s};
    endfunction

    ////////////////////
    // Reference model
    ////////////////////
    always @(posedge CLK125 or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_m   = 0;
            stage_m = '0;
            ctrl_m  = '0;
            exp_out = '0;
        end else begin
            exp_out = expected_link(cnt_m, stage_m);
            stage_m = samples_flat[12*ctrl_m[3:0] +: 12];   // Channel as it was before the edge
            cnt_m   = (cnt_m == int'(FRAME_LEN) - 1) ? 0 : cnt_m + 1;
            if (b_hs_i && bresp_i !== exp_bresp) begin
                bus_errors++;
                $display("[ERROR] %0t: BRESP %b, expected %b", $time, bresp_i, exp_bresp);
            end
            if (r_hs_i && {rresp_i, rdata_i} !== {exp_rresp, exp_rdata}) begin
                bus_errors++;
                $display("[ERROR] %0t: read %h resp %b, expected %h resp %b",
                         $time, rdata_i, rresp_i, exp_rdata, exp_rresp);
            end
            if (ar_hs_i) begin                      // Old register value is read
                exp_rdata = (araddr_i == adc_link_pkg::CTRL_ADDR) ? ctrl_m : '0;
                exp_rresp = (araddr_i == adc_link_pkg::CTRL_ADDR) ?
                            adc_link_pkg::RESP_OKAY : adc_link_pkg::RESP_SLVERR;
            end
            if (wr_hs_i) begin
                exp_bresp = (awaddr_i == adc_link_pkg::CTRL_ADDR) ?
                            adc_link_pkg::RESP_OKAY : adc_link_pkg::RESP_SLVERR;
                if (awaddr_i == adc_link_pkg::CTRL_ADDR) ctrl_m = wdata_i;
            end
        end
    end

    // Outputs settled by the falling edge
    always @(negedge CLK125) begin
        if ({tx_charisk_i, tx_data_i} !== exp_out) begin
            link_errors++;
            $display("[ERROR] %0t: link %h k %b, expected %h k %b", $time,
                     tx_data_i, tx_charisk_i, exp_out[15:0], exp_out[17:16]);
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_adc_link.sv
`timescale 1ns/10ps
`default_nettype none

module tb_adc_link;

    localparam int unsigned FRAME_LEN = 64;
    localparam int unsigned COMMA_LEN = 10;
    localparam int TIMEOUT = 200;                   // Cycles per handshake wait

    logic CLK125;
    logic rst_n_i;
    adc_link_pkg::sample_t [adc_link_pkg::NUM_CHAN-1:0] adc_samples;
    adc_link_pkg::axil_addr_t awaddr, araddr;
    adc_link_pkg::axil_data_t wdata, rdata;
    adc_link_pkg::axil_resp_t bresp, rresp;
    adc_link_pkg::link_word_t tx_data;
    adc_link_pkg::link_k_t    tx_charisk;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    int   seed = 32'hd718c141;
    int   tb_errors = 0;                            // Bus timing faults seen here

    // 40 ns period
    initial begin
        CLK125 = 1'b0;
        forever #20 CLK125 = ~CLK125;
    end

    adc_link_top #(.FRAME_LEN(FRAME_LEN), .COMMA_LEN(COMMA_LEN)) u_adc_link_top (
        .CLK125(CLK125), .rst_n_i(rst_n_i), .adc_samples_i(adc_samples),
        .s_axil_awaddr_i(awaddr), .s_axil_awvalid_i(awvalid), .s_axil_awready_o(awready),
        .s_axil_wdata_i(wdata), .s_axil_wvalid_i(wvalid), .s_axil_wready_o(wready),
        .s_axil_bresp_o(bresp), .s_axil_bvalid_o(bvalid), .s_axil_bready_i(bready),
        .s_axil_araddr_i(araddr), .s_axil_arvalid_i(arvalid), .s_axil_arready_o(arready),
        .s_axil_rdata_o(rdata), .s_axil_rresp_o(rresp), .s_axil_rvalid_o(rvalid),
        .s_axil_rready_i(rready), .tx_data_o(tx_data), .tx_charisk_o(tx_charisk)
    );

    adc_link_checker #(.FRAME_LEN(FRAME_LEN), .COMMA_LEN(COMMA_LEN)) u_checker (
        .CLK125(CLK125), .rst_n_i(rst_n_i), .adc_samples_i(adc_samples),
        .awaddr_i(awaddr), .wdata_i(wdata),
        .wr_hs_i(awvalid & awready & wvalid & wready),
        .b_hs_i(bvalid & bready), .bresp_i(bresp),
        .araddr_i(araddr), .ar_hs_i(arvalid & arready),
        .r_hs_i(rvalid & rready), .rdata_i(rdata), .rresp_i(rresp),
        .tx_data_i(tx_data), .tx_charisk_i(tx_charisk)
    );

    // Fresh samples on every channel, every cycle
    initial begin
        adc_samples = '0;
        forever begin
            @(negedge CLK125);
            for (int k = 0; k < adc_link_pkg::NUM_CHAN; k++) begin
                adc_samples[k] = 12'($random(seed));
            end
        end
    end

    task automatic abort_run(input string msg);
        $display("Timeout: %s", msg);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    ////////////////////
    // Bus tasks
    ////////////////////
    // hold > 0 keeps BREADY low that many cycles while a second write is offered
    task automatic axil_write(input adc_link_pkg::axil_addr_t addr,
                              input adc_link_pkg::axil_data_t data, input int hold);
        int n;
        int i;
        @(negedge CLK125);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = (hold == 0);
        n = 0;
        do begin
            @(posedge CLK125);
            n++;
            if (awready !== wready) begin
                tb_errors++;
                $display("[ERROR] %0t: AWREADY %b and WREADY %b differ",
                         $time, awready, wready);
            end
        end while (!(awready && wready) && n < TIMEOUT);
        if (!(awready && wready)) abort_run("write address never accepted");
        @(negedge CLK125);
        for (i = 0; i < hold; i++) begin
            if (!bvalid || awready || wready) begin
                tb_errors++;
                $display("[ERROR] %0t: back-pressure not held, BVALID %b AWREADY %b WREADY %b",
                         $time, bvalid, awready, wready);
            end
            @(negedge CLK125);
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        n = 0;
        while (!bvalid && n < TIMEOUT) begin
            @(negedge CLK125);
            n++;
        end
        if (!bvalid) abort_run("write response never came");
        @(negedge CLK125);                          // B handshake done
        if (bvalid) begin
            tb_errors++;
            $display("[ERROR] %0t: BVALID still high after the B handshake", $time);
        end
    endtask

    // hold > 0 keeps RREADY low that many cycles while a second read is offered
    task automatic axil_read(input adc_link_pkg::axil_addr_t addr, input int hold);
        int n;
        int i;
        @(negedge CLK125);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (hold == 0);
        n = 0;
        do begin
            @(posedge CLK125);
            n++;
        end while (!arready && n < TIMEOUT);
        if (!arready) abort_run("read address never accepted");
        @(negedge CLK125);
        for (i = 0; i < hold; i++) begin
            if (!rvalid || arready) begin
                tb_errors++;
                $display("[ERROR] %0t: back-pressure not held, RVALID %b ARREADY %b",
                         $time, rvalid, arready);
            end
            @(negedge CLK125);
        end
        arvalid = 1'b0;
        rready  = 1'b1;
        n = 0;
        while (!rvalid && n < TIMEOUT) begin
            @(negedge CLK125);
            n++;
        end
        if (!rvalid) abort_run("read data never came");
        @(negedge CLK125);
        if (rvalid) begin
            tb_errors++;
            $display("[ERROR] %0t: RVALID still high after the R handshake", $time);
        end
    endtask

    ////////////////////
    // Test sequence
    ////////////////////
    initial begin
        rst_n_i = 1'b0;
        {awaddr, wdata, awvalid, wvalid, bready} = '0;
        {araddr, arvalid, rready} = '0;
        repeat (8) @(negedge CLK125);
        rst_n_i = 1'b1;
        repeat (3 * FRAME_LEN) @(negedge CLK125);   // Bursts and channel 0 data
        for (int ch = 0; ch < adc_link_pkg::NUM_CHAN; ch++) begin
            axil_write(adc_link_pkg::CTRL_ADDR, {28'($random(seed)), 4'(ch)}, 0);
            repeat (40) @(negedge CLK125);
            axil_read(adc_link_pkg::CTRL_ADDR, 0);  // Full 32 bits back
        end
        axil_write(4'h8, 32'h0000_0003, 0);         // Unmapped, SLVERR
        axil_read(4'h8, 0);
        repeat (20) @(negedge CLK125);
        axil_write(adc_link_pkg::CTRL_ADDR, 32'hA5A5_0005, 20);
        axil_read(adc_link_pkg::CTRL_ADDR, 20);
        repeat (2 * FRAME_LEN) @(negedge CLK125);
        $display("Errors: checker %0d, testbench %0d", u_checker.errors, tb_errors);
        if (u_checker.errors == 0 && tb_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
hdl/adc_link_pkg.sv
hdl/axil_if.sv
hdl/axil_csr_regs.sv
hdl/chan_select.sv
hdl/link_framer.sv
hdl/adc_link_top.sv
tests/adc_link_assertions.sv
tests/adc_link_checker.sv
tests/tb_adc_link.sv

// File: Makefile
TOP := tb_adc_link

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -o V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
